/* hw/neuron_pkg.sv */
`default_nettype none

package neuron_pkg;

    // single precision field layout
    localparam int FLOAT_W = 32;            // whole potential word
    localparam int EXP_W   = 8;             // biased exponent
    localparam int MAN_W   = 23;            // stored mantissa, hidden one not kept
    localparam int SIG_W   = MAN_W + 1;     // significand with hidden one

    // per-lane decay rate, one bit per power-of-two divide
    typedef logic [3:0] decay_rate_t;

    localparam decay_rate_t RATE_DIV1          = 4'b0001;  // hold value
    localparam decay_rate_t RATE_DIV2          = 4'b0010;  // exponent - 1
    localparam decay_rate_t RATE_DIV4          = 4'b0100;  // exponent - 2
    localparam decay_rate_t RATE_DIV8          = 4'b1000;  // exponent - 3
    localparam decay_rate_t RATE_THREE_QUARTER = 4'b0011;  // half plus quarter

    // any code not listed above decays as RATE_DIV1

endpackage

`default_nettype wire

/* hw/timestep_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module timestep_gen #(
    parameter int TICK_CYCLES = 16              // clocks per timestep
) (
    input  wire  CLK_Decay5,
    input  wire  rst,
    output logic tick                           // one clock per timestep
);

    localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_CYCLES - 1);

    logic [CNT_W-1:0] cnt;                      // position inside timestep
    logic             wrap;                     // last clock of timestep

    assign wrap = (cnt == CNT_LAST);

    always_ff @(posedge CLK_Decay5) begin
        if (rst) begin
            cnt  <= '0;                         // restart, first tick TICK_CYCLES later
            tick <= 1'b0;
        end else begin
            tick <= wrap;                       // registered pulse on wrap
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/potential_loader.sv */
`default_nettype none
`timescale 1ns/100ps

module potential_loader
    import neuron_pkg::*;
#(
    parameter int NUM_LANES  = 4,
    parameter int LANE_IDX_W = 2
) (
    input  wire                    CLK_Decay5,
    input  wire                    rst,
    input  wire                    load,            // one-cycle load strobe
    input  wire [LANE_IDX_W-1:0]   load_lane,       // target lane index
    input  wire [FLOAT_W-1:0]      load_potential,
    input  wire decay_rate_t       load_rate,
    output logic [NUM_LANES-1:0]   lane_we,         // one-hot, one clock
    output logic [FLOAT_W-1:0]     wr_potential,    // shared by all lanes
    output decay_rate_t            wr_rate
);

    logic [NUM_LANES-1:0] we_dec;                   // decoded strobe

    // index to one-hot, indices past NUM_LANES-1 hit nothing
    always_comb begin
        we_dec = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (load && (load_lane == LANE_IDX_W'(i))) begin
                we_dec[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK_Decay5) begin
        if (rst) begin
            lane_we <= '0;
        end else begin
            lane_we <= we_dec;                      // drops back next clock
        end
    end

    // write data follows the strobe, lanes only look at it under lane_we
    always_ff @(posedge CLK_Decay5) begin
        if (load) begin
            wr_potential <= load_potential;
            wr_rate      <= load_rate;
        end
    end

endmodule

`default_nettype wire

/* hw/potential_decay_lane.sv */
`default_nettype none
`timescale 1ns/100ps

module potential_decay_lane
    import neuron_pkg::*;
(
    input  wire               CLK_Decay5,
    input  wire               rst,
    input  wire               tick,             // apply one decay step
    input  wire               we,               // write from loader
    input  wire [FLOAT_W-1:0] wr_potential,
    input  wire decay_rate_t  wr_rate,
    input  wire               fire,             // clear after a spike
    output logic [FLOAT_W-1:0] potential,
    output logic              updated           // pulse after tick edge
);

    logic [FLOAT_W-1:0] pot_q;                  // membrane potential
    decay_rate_t        rate_q;                 // this lane's rate code

    logic               sign;
    logic [EXP_W-1:0]   exp_in;
    logic [MAN_W-1:0]   man_in;
    logic [SIG_W-1:0]   sig;                    // 1.mantissa
    logic [SIG_W-1:0]   sig_3q;                 // sig - sig/4, truncated
    logic [1:0]         exp_dec;                // exponent drop this step
    logic [MAN_W-1:0]   man_out;
    logic [EXP_W:0]     exp_diff;               // extra bit catches borrow
    logic               flush;                  // result goes to signed zero
    logic [FLOAT_W-1:0] decayed;

    assign sign   = pot_q[FLOAT_W-1];
    assign exp_in = pot_q[FLOAT_W-2 -: EXP_W];
    assign man_in = pot_q[MAN_W-1:0];
    assign sig    = {1'b1, man_in};
    assign sig_3q = sig - (sig >> 2);           // 0.75 * sig, never below 2^22

    // divides only touch the exponent, 3/4 may need one left shift
    always_comb begin
        man_out = man_in;
        case (rate_q)
            RATE_DIV1: exp_dec = 2'd0;
            RATE_DIV2: exp_dec = 2'd1;
            RATE_DIV4: exp_dec = 2'd2;
            RATE_DIV8: exp_dec = 2'd3;
            RATE_THREE_QUARTER: begin
                if (sig_3q[SIG_W-1]) begin
                    exp_dec = 2'd0;             // still normalized
                    man_out = sig_3q[MAN_W-1:0];
                end else begin
                    exp_dec = 2'd1;             // renormalize by one
                    man_out = {sig_3q[MAN_W-2:0], 1'b0};
                end
            end
            default: exp_dec = 2'd0;            // unknown code acts as div1
        endcase
    end

    assign exp_diff = {1'b0, exp_in} - (EXP_W + 1)'(exp_dec);

    // zero or denormal input, or exponent at or below zero after the drop
    assign flush = (exp_in == '0) || exp_diff[EXP_W] || (exp_diff[EXP_W-1:0] == '0);

    assign decayed = flush ? {sign, {(FLOAT_W-1){1'b0}}}
                           : {sign, exp_diff[EXP_W-1:0], man_out};

    always_ff @(posedge CLK_Decay5) begin
        if (rst) begin
            pot_q   <= '0;
            rate_q  <= RATE_DIV1;
            updated <= 1'b0;
        end else begin
            updated <= tick;                    // all lanes pulse together
            if (we) begin                       // write beats tick and fire
                pot_q  <= wr_potential;
                rate_q <= wr_rate;
            end else if (tick) begin
                pot_q  <= decayed;
            end else if (fire) begin
                pot_q  <= '0;                   // reset after spike
            end
        end
    end

    assign potential = pot_q;

endmodule

`default_nettype wire

/* hw/spike_collector.sv */
`default_nettype none
`timescale 1ns/100ps

module spike_collector
    import neuron_pkg::*;
#(
    parameter int                 NUM_LANES  = 4,
    parameter int                 LANE_IDX_W = 2,
    parameter logic [FLOAT_W-1:0] THRESHOLD  = 32'h4100_0000  // 8.0
) (
    input  wire                           CLK_Decay5,
    input  wire                           rst,
    input  wire [NUM_LANES*FLOAT_W-1:0]   lane_potential,  // lane i at word i
    input  wire [NUM_LANES-1:0]           lane_updated,
    input  wire [LANE_IDX_W-1:0]          rd_lane,
    output logic [NUM_LANES-1:0]          spikes,          // held until next step
    output logic                          step_done,       // one clock per step
    output logic [NUM_LANES-1:0]          fire,            // clear request to lanes
    output logic [FLOAT_W-1:0]            rd_potential
);

    logic [FLOAT_W-1:0]   words [NUM_LANES];     // unpacked lane view
    logic [NUM_LANES-1:0] over_th;              // lane at or above threshold
    logic                 step;                 // decayed values are valid

    // lanes update in lockstep, lane 0 stands for all of them
    assign step = lane_updated[0];

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_cmp
        assign words[i] = lane_potential[i*FLOAT_W +: FLOAT_W];
        // positive floats order like unsigned integers
        assign over_th[i] = !words[i][FLOAT_W-1] && (words[i] >= THRESHOLD);
    end

    always_ff @(posedge CLK_Decay5) begin
        if (rst) begin
            spikes    <= '0;
            fire      <= '0;
            step_done <= 1'b0;
        end else begin
            step_done <= step;
            fire      <= step ? over_th : '0;   // single-clock clear strobe
            if (step) begin
                spikes <= over_th;
            end
        end
    end

    // readback mux, unused indices read as zero
    always_comb begin
        rd_potential = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (rd_lane == LANE_IDX_W'(i)) begin
                rd_potential = words[i];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/neuron_decay_core.sv */
`default_nettype none
`timescale 1ns/100ps

module neuron_decay_core
    import neuron_pkg::*;
#(
    parameter int                 NUM_LANES   = 4,
    parameter int                 TICK_CYCLES = 16,
    parameter logic [FLOAT_W-1:0] THRESHOLD   = 32'h4100_0000,  // 8.0
    localparam int                LANE_IDX_W  = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  wire                    CLK_Decay5,
    input  wire                    rst,
    input  wire                    load,
    input  wire [LANE_IDX_W-1:0]   load_lane,
    input  wire [FLOAT_W-1:0]      load_potential,
    input  wire decay_rate_t       load_rate,
    input  wire [LANE_IDX_W-1:0]   rd_lane,
    output logic [FLOAT_W-1:0]     rd_potential,
    output logic [NUM_LANES-1:0]   spikes,
    output logic                   step_done,
    output logic                   tick            // exported timestep pulse
);

    logic [NUM_LANES-1:0]         lane_we;          // loader one-hot write
    logic [FLOAT_W-1:0]           wr_potential;
    decay_rate_t                  wr_rate;
    logic [NUM_LANES*FLOAT_W-1:0] lane_potential;   // flat, lane i at word i
    logic [NUM_LANES-1:0]         lane_updated;
    logic [NUM_LANES-1:0]         fire;             // collector back to lanes

    timestep_gen #(
        .TICK_CYCLES (TICK_CYCLES)
    ) timestep_gen_i (
        .CLK_Decay5 (CLK_Decay5),
        .rst        (rst),
        .tick       (tick)
    );

    potential_loader #(
        .NUM_LANES  (NUM_LANES),
        .LANE_IDX_W (LANE_IDX_W)
    ) potential_loader_i (
        .CLK_Decay5     (CLK_Decay5),
        .rst            (rst),
        .load           (load),
        .load_lane      (load_lane),
        .load_potential (load_potential),
        .load_rate      (load_rate),
        .lane_we        (lane_we),
        .wr_potential   (wr_potential),
        .wr_rate        (wr_rate)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        potential_decay_lane potential_decay_lane_i (
            .CLK_Decay5   (CLK_Decay5),
            .rst          (rst),
            .tick         (tick),
            .we           (lane_we[i]),
            .wr_potential (wr_potential),
            .wr_rate      (wr_rate),
            .fire         (fire[i]),
            .potential    (lane_potential[i*FLOAT_W +: FLOAT_W]),
            .updated      (lane_updated[i])
        );
    end

    spike_collector #(
        .NUM_LANES  (NUM_LANES),
        .LANE_IDX_W (LANE_IDX_W),
        .THRESHOLD  (THRESHOLD)
    ) spike_collector_i (
        .CLK_Decay5     (CLK_Decay5),
        .rst            (rst),
        .lane_potential (lane_potential),
        .lane_updated   (lane_updated),
        .rd_lane        (rd_lane),
        .spikes         (spikes),
        .step_done      (step_done),
        .fire           (fire),
        .rd_potential   (rd_potential)
    );

endmodule

`default_nettype wire

/* sim/neuron_decay_chk.sv */
`default_nettype none
`timescale 1ns/100ps

module neuron_decay_chk
    import neuron_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input wire                         CLK_Decay5,
    input wire                         rst,
    input wire [NUM_LANES*FLOAT_W-1:0] lane_potential,  // lane i at word i
    input wire [NUM_LANES-1:0]         spikes,
    input wire                         step_done,
    input wire [NUM_LANES-1:0]         fire
);

    logic [NUM_LANES-1:0] sign_bits;            // sign of each lane word
    int                   fail_count;           // assertion failures so far

    initial fail_count = 0;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_sign
        assign sign_bits[i] = lane_potential[i*FLOAT_W + FLOAT_W - 1];
    end

    done_one_clock: assert property (
        @(posedge CLK_Decay5) disable iff (rst) step_done |=> !step_done
    ) else begin
        $error("step_done stayed high for a second clock");
        fail_count++;
    end

    fire_matches_spikes: assert property (
        @(posedge CLK_Decay5) disable iff (rst) step_done |-> (fire == spikes)
    ) else begin
        $error("fire differs from spikes during step_done");
        fail_count++;
    end

    // spikes were registered from the words one clock earlier
    no_negative_spike: assert property (
        @(posedge CLK_Decay5) disable iff (rst)
            step_done |-> ((spikes & $past(sign_bits)) == '0)
    ) else begin
        $error("spike flagged on a lane with a negative potential");
        fail_count++;
    end

endmodule

`default_nettype wire

/* sim/decay_monitor.sv */
`default_nettype none
`timescale 1ns/100ps

module decay_monitor
    import neuron_pkg::*;
#(
    parameter int                 NUM_LANES   = 3,
    parameter int                 LANE_IDX_W  = 2,
    parameter int                 TICK_CYCLES = 16,             // clocks per timestep
    parameter logic [FLOAT_W-1:0] THRESHOLD   = 32'h4100_0000  // 8.0
) (
    input  wire                  CLK_Decay5,
    input  wire                  rst,
    input  wire                  load,
    input  wire [LANE_IDX_W-1:0] load_lane,
    input  wire [FLOAT_W-1:0]    load_potential,
    input  wire decay_rate_t     load_rate,
    input  wire [LANE_IDX_W-1:0] rd_lane,
    input  wire                  rd_check,         // readback valid this cycle
    input  wire [FLOAT_W-1:0]    rd_potential,
    input  wire [NUM_LANES-1:0]  spikes,
    input  wire                  step_done,
    input  wire                  tick,
    output int                   err_count
);

    logic [FLOAT_W-1:0] shadow_pot  [NUM_LANES];   // expected lane contents
    decay_rate_t        shadow_rate [NUM_LANES];
    logic               pend_valid;                // load still in the loader
    int                 pend_lane;
    logic [FLOAT_W-1:0] pend_pot;
    decay_rate_t        pend_rate;
    int                 tick_gap;                  // clocks since last tick or reset
    logic               tick_d1;                   // tick seen one clock ago
    logic               tick_d2;                   // tick seen two clocks ago

    // one timestep of decay on an unpacked float, truncating
    function automatic logic [FLOAT_W-1:0] decay_ref(
        input logic [FLOAT_W-1:0] value,
        input decay_rate_t        rate
    );
        logic        s;
        int          e;
        int unsigned sig;
        s   = value[31];
        e   = int'(value[30:23]);
        sig = {1'b1, value[22:0]};              // hidden one restored
        if (e == 0) begin
            return {s, 31'd0};                  // zero or denormal in
        end
        case (rate)
            RATE_DIV2: e = e - 1;
            RATE_DIV4: e = e - 2;
            RATE_DIV8: e = e - 3;
            RATE_THREE_QUARTER: begin
                sig = sig - sig / 4;            // half plus quarter
                if (sig < 32'h0080_0000) begin
                    sig = sig * 2;              // back to 1.x form
                    e   = e - 1;
                end
            end
            default: e = e;                     // div1 and unknown codes
        endcase
        if (e <= 0) begin
            return {s, 31'd0};                  // underflow
        end
        return {s, e[7:0], sig[22:0]};
    endfunction

    initial err_count = 0;

    always @(posedge CLK_Decay5) begin
        logic [NUM_LANES-1:0] exp_spikes;
        logic                 exp_tick;
        if (rst) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                shadow_pot[i]  = '0;
                shadow_rate[i] = RATE_DIV1;
            end
            pend_valid = 1'b0;
            tick_gap   = 0;
            tick_d1    = 1'b0;
            tick_d2    = 1'b0;
        end else begin
            // tick every TICK_CYCLES clocks, step_done two clocks behind it
            exp_tick = (tick_gap == TICK_CYCLES);
            if (tick !== exp_tick) begin
                $display("FAIL tick expected %h actual %h", exp_tick, tick);
                err_count++;
            end
            if (step_done !== tick_d2) begin
                $display("FAIL step_done expected %h actual %h", tick_d2, step_done);
                err_count++;
            end
            tick_gap = tick ? 1 : tick_gap + 1;
            tick_d2  = tick_d1;
            tick_d1  = tick;
            // readback shows the state before this edge
            if (rd_check && rd_lane < NUM_LANES && rd_potential !== shadow_pot[rd_lane]) begin
                $display("FAIL rd_potential lane %0d expected %h actual %h",
                         rd_lane, shadow_pot[rd_lane], rd_potential);
                err_count++;
            end
            if (step_done) begin
                exp_spikes = '0;
                for (int i = 0; i < NUM_LANES; i++) begin
                    shadow_pot[i] = decay_ref(shadow_pot[i], shadow_rate[i]);
                    exp_spikes[i] = !shadow_pot[i][31] && (shadow_pot[i] >= THRESHOLD);
                end
                if (spikes !== exp_spikes) begin
                    $display("FAIL spikes expected %h actual %h", exp_spikes, spikes);
                    err_count++;
                end
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (exp_spikes[i]) shadow_pot[i] = '0;  // fired lanes clear
                end
            end
            if (pend_valid) begin                   // write lands after clear
                shadow_pot[pend_lane]  = pend_pot;
                shadow_rate[pend_lane] = pend_rate;
            end
            pend_valid = load && (load_lane < NUM_LANES);  // bad index writes nothing
            pend_lane  = int'(load_lane);
            pend_pot   = load_potential;
            pend_rate  = load_rate;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_neuron_decay_core.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_neuron_decay_core
    import neuron_pkg::*;
();

    localparam int                 NUM_LANES   = 3;      // index 3 has no lane
    localparam int                 LANE_IDX_W  = $clog2(NUM_LANES);
    localparam int                 TICK_CYCLES = 16;
    localparam logic [FLOAT_W-1:0] THRESHOLD   = 32'h4100_0000;  // 8.0
    localparam int                 NUM_STEPS   = 80;
    localparam int                 TICK_WAIT   = TICK_CYCLES + 4;  // clocks before giving up
    localparam int                 DONE_WAIT   = 6;
    localparam decay_rate_t        UNDEF_CODES [7] = '{4'h0, 4'h5, 4'h6, 4'h7, 4'h9, 4'hc, 4'hf};

    logic                  CLK_Decay5;
    logic                  rst;
    logic                  load;
    logic [LANE_IDX_W-1:0] load_lane;
    logic [FLOAT_W-1:0]    load_potential;
    decay_rate_t           load_rate;
    logic [LANE_IDX_W-1:0] rd_lane;
    logic [FLOAT_W-1:0]    rd_potential;
    logic [NUM_LANES-1:0]  spikes;
    logic                  step_done;
    logic                  tick;
    logic                  rd_check;                     // monitor compares readback
    int                    mismatch_count;
    int                    timeout_count;
    int                    assert_count;
    int                    seed;

    initial begin
        CLK_Decay5 = 1'b0;
        forever #2 CLK_Decay5 = ~CLK_Decay5;            // 4 ns period
    end

    neuron_decay_core #(
        .NUM_LANES   (NUM_LANES),
        .TICK_CYCLES (TICK_CYCLES),
        .THRESHOLD   (THRESHOLD)
    ) neuron_decay_core_i (
        .CLK_Decay5     (CLK_Decay5),
        .rst            (rst),
        .load           (load),
        .load_lane      (load_lane),
        .load_potential (load_potential),
        .load_rate      (load_rate),
        .rd_lane        (rd_lane),
        .rd_potential   (rd_potential),
        .spikes         (spikes),
        .step_done      (step_done),
        .tick           (tick)
    );

    decay_monitor #(
        .NUM_LANES   (NUM_LANES),
        .LANE_IDX_W  (LANE_IDX_W),
        .TICK_CYCLES (TICK_CYCLES),
        .THRESHOLD   (THRESHOLD)
    ) decay_monitor_i (
        .CLK_Decay5     (CLK_Decay5),
        .rst            (rst),
        .load           (load),
        .load_lane      (load_lane),
        .load_potential (load_potential),
        .load_rate      (load_rate),
        .rd_lane        (rd_lane),
        .rd_check       (rd_check),
        .rd_potential   (rd_potential),
        .spikes         (spikes),
        .step_done      (step_done),
        .tick           (tick),
        .err_count      (mismatch_count)
    );

    bind spike_collector neuron_decay_chk #(
        .NUM_LANES (NUM_LANES)
    ) neuron_decay_chk_i (
        .CLK_Decay5     (CLK_Decay5),
        .rst            (rst),
        .lane_potential (lane_potential),
        .spikes         (spikes),
        .step_done      (step_done),
        .fire           (fire)
    );

    task automatic step_clock();
        @(posedge CLK_Decay5);
        #0.5;                                            // inputs move after the edge
    endtask

    task automatic wait_for_tick(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < TICK_WAIT && !ok; n++) begin
            step_clock();
            ok = tick;
        end
        if (!ok) begin
            $display("Timed out waiting for a timestep tick.");
            timeout_count++;
        end
    endtask

    task automatic wait_for_step_done(output bit ok);
        ok = step_done;
        for (int n = 0; n < DONE_WAIT && !ok; n++) begin
            step_clock();
            ok = step_done;
        end
        if (!ok) begin
            $display("Timed out waiting for step_done after a tick.");
            timeout_count++;
        end
    endtask

    task automatic write_lane(input int lane, input logic [FLOAT_W-1:0] value,
                              input decay_rate_t rate);
        load           = 1'b1;                           // one-cycle strobe
        load_lane      = LANE_IDX_W'(lane);
        load_potential = value;
        load_rate      = rate;
        step_clock();
        load = 1'b0;
    endtask

    task automatic read_back_lanes();
        repeat (2) step_clock();                         // fire clear has landed
        for (int l = 0; l < NUM_LANES; l++) begin
            rd_lane  = LANE_IDX_W'(l);
            rd_check = 1'b1;
            step_clock();
        end
        rd_check = 1'b0;
    endtask

    function automatic logic [FLOAT_W-1:0] random_value();
        int   kind;
        logic s;
        int   e;
        kind = $unsigned($random(seed)) % 5;
        s    = 1'($random(seed));
        e    = 124 + $unsigned($random(seed)) % 12;      // near the 8.0 exponent
        case (kind)
            1: s = 1'b1;                                 // negative
            2: e = 1 + $unsigned($random(seed)) % 4;     // about to underflow
            3: return {s, 31'd0};                        // signed zero
            4: e = 1 + $unsigned($random(seed)) % 254;   // any normal
            default: s = 1'b0;
        endcase
        return {s, 8'(e), 23'($random(seed))};
    endfunction

    function automatic decay_rate_t random_rate();
        case ($unsigned($random(seed)) % 6)
            0: return RATE_DIV1;
            1: return RATE_DIV2;
            2: return RATE_DIV4;
            3: return RATE_DIV8;
            4: return RATE_THREE_QUARTER;
            default: return UNDEF_CODES[$unsigned($random(seed)) % 7];
        endcase
    endfunction

    initial begin
        bit ok;
        seed           = 32'h158d_4b87;
        rst            = 1'b1;
        load           = 1'b0;
        load_lane      = '0;
        load_potential = '0;
        load_rate      = RATE_DIV1;
        rd_lane        = '0;
        rd_check       = 1'b0;
        timeout_count  = 0;
        repeat (8) step_clock();
        rst = 1'b0;
        for (int s = 0; s < NUM_STEPS; s++) begin
            wait_for_tick(ok);
            if (!ok) break;
            step_clock();                                // cycle after the tick
            if (s % 4 != 3) begin
                write_lane($unsigned($random(seed)) % (NUM_LANES + 1), random_value(),
                           random_rate());
            end
            wait_for_step_done(ok);
            if (!ok) break;
            read_back_lanes();
        end
        assert_count = neuron_decay_core_i.spike_collector_i.neuron_decay_chk_i.fail_count;
        $display("mismatches %0d, timeouts %0d, assertion failures %0d",
                 mismatch_count, timeout_count, assert_count);
        if (mismatch_count == 0 && timeout_count == 0 && assert_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hw/neuron_pkg.sv
hw/timestep_gen.sv
hw/potential_loader.sv
hw/potential_decay_lane.sv
hw/spike_collector.sv
hw/neuron_decay_core.sv
sim/neuron_decay_chk.sv
sim/decay_monitor.sv
sim/tb_neuron_decay_core.sv

/* Bender.yml */
package:
  name: neuron_decay_core

sources:
  - hw/neuron_pkg.sv
  - hw/timestep_gen.sv
  - hw/potential_loader.sv
  - hw/potential_decay_lane.sv
  - hw/spike_collector.sv
  - hw/neuron_decay_core.sv
  - target: simulation
    files:
      - sim/neuron_decay_chk.sv
      - sim/decay_monitor.sv
      - sim/tb_neuron_decay_core.sv
